/* build.f */
+incdir+src
src/cuPkg.sv
src/opcodeDecoder.sv
src/controlSequencer.sv
src/controlWordGen.sv
src/controlUnit.sv
sim/tb_controlUnit.sv

/* Bender.yml */
package:
  name: controlUnit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/cuPkg.sv
      - src/opcodeDecoder.sv
      - src/controlSequencer.sv
      - src/controlWordGen.sv
      - src/controlUnit.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_controlUnit.sv

/* sim/cu_stimulus.txt */
# opcode funct overflow divZero ackDelay(-1 = random) writes selects aluOp cause
# writes/selects/aluOp (binary) are for the result cycle; cause 0 None 1 Ovf 2 Invalid 3 DivZero
00 20 0 0 0 000010000 100010000000 001 0
00 22 0 0 0 000010000 100010000000 010 0
00 24 0 0 0 000010000 100010000000 011 0
00 2a 0 0 0 000010000 100010000000 111 0
08 00 0 0 0 000010000 110000000000 001 0
09 00 0 0 0 000010000 110000000000 001 0
0a 00 0 0 0 000010000 110000000000 111 0
0f 00 0 0 0 000010000 000001000000 000 0
2b 00 0 0 0 000001000 110000000100 001 0
00 10 0 0 0 000010000 000010100000 000 0
00 12 0 0 0 000010000 000010110000 000 0
02 00 0 0 0 100000000 000000000001 000 0
03 00 0 0 0 100010000 000100010001 000 0
00 08 0 0 0 100000000 000000000010 000 0
00 20 1 0 0 000000000 100010000000 001 1
00 22 1 0 0 000000000 100010000000 010 1
08 00 1 0 0 000000000 110000000000 001 1
09 00 1 0 0 000010000 110000000000 001 0
04 00 0 0 0 100000001 001000000011 010 2
00 3f 0 0 0 100000001 001000000011 010 2
00 18 0 0 3 000000110 000000000000 000 0
00 1a 0 0 0 000000110 000000000000 000 0
00 18 0 0 -1 000000110 000000000000 000 0
00 1a 0 0 -1 000000110 000000000000 000 0
00 1a 0 1 0 100000001 001000000011 010 3
00 18 0 1 2 000000110 000000000000 000 0
00 20 0 0 0 000010000 100010000000 001 0

/* sim/tb_controlUnit.sv */
`timescale 1ns/1ps
`include "cu_macros.svh"

module tb_controlUnit;

  localparam int WaitLimit = 64;
  localparam int MaxRandomDelay = 6;

  logic                clk;
  logic                reset;
  cuPkg::opcodeT       opcode;
  cuPkg::functT        funct;
  cuPkg::flagsT        flags;
  logic                muldivAck;
  cuPkg::writeEnablesT writes;
  cuPkg::muxSelectsT   selects;
  cuPkg::aluOpT        aluOp;
  logic                muldivReq;
  logic                muldivDiv;
  cuPkg::excCauseT     excCause;

  controlUnit i_controlUnit (
    .clk       (clk),
    .reset     (reset),
    .opcode    (opcode),
    .funct     (funct),
    .flags     (flags),
    .muldivAck (muldivAck),
    .writes    (writes),
    .selects   (selects),
    .aluOp     (aluOp),
    .muldivReq (muldivReq),
    .muldivDiv (muldivDiv),
    .excCause  (excCause)
  );

  always #20 clk = ~clk;

  task automatic stopRun();
    $display("Errors found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic checkWrites(input string testName, input cuPkg::writeEnablesT expected,
                             input cuPkg::writeEnablesT actual);
    if (actual !== expected) begin
      $display("ERROR %s: writes expected %b, actual %b", testName, expected, actual);
      stopRun();
    end
  endtask

  task automatic checkSelects(input string testName, input cuPkg::muxSelectsT expected,
                              input cuPkg::muxSelectsT actual);
    if (actual !== expected) begin
      $display("ERROR %s: selects expected %b, actual %b", testName, expected, actual);
      stopRun();
    end
  endtask

  task automatic checkAluOp(input string testName, input cuPkg::aluOpT expected,
                            input cuPkg::aluOpT actual);
    if (actual !== expected) begin
      $display("ERROR %s: aluOp expected %b, actual %b", testName, expected, actual);
      stopRun();
    end
  endtask

  task automatic checkCause(input string testName, input cuPkg::excCauseT expected,
                            input cuPkg::excCauseT actual);
    if (actual !== expected) begin
      $display("ERROR %s: excCause expected %s, actual %s (%b)", testName, expected.name(),
               actual.name(), actual);
      stopRun();
    end
  endtask

  task automatic checkBit(input string testName, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %b, actual %b", testName, expected, actual);
      stopRun();
    end
  endtask

  task automatic nextCycle();
    @(negedge clk);
  endtask

  task automatic checkCycle(input string testName, input cuPkg::writeEnablesT expW,
                            input cuPkg::muxSelectsT expS, input cuPkg::aluOpT expA,
                            input cuPkg::excCauseT expCause, input logic expReq);
    checkWrites(testName, expW, writes);
    checkSelects(testName, expS, selects);
    checkAluOp(testName, expA, aluOp);
    checkCause(testName, expCause, excCause);
    checkBit({testName, " muldivReq"}, expReq, muldivReq);
  endtask

  // Idle Fetch0 cycle with the memory address from PC
  task automatic checkFetchZero(input string testName);
    cuPkg::muxSelectsT s;
    s = '0;
    s.iorD = `CU_IORD_PC;
    checkCycle(testName, '0, s, `CU_ALU_PASS, cuPkg::None, 1'b0);
  endtask

  task automatic checkException(input string testName, input cuPkg::excCauseT cause);
    cuPkg::writeEnablesT w;
    cuPkg::muxSelectsT   s;
    w = '0;
    w.pcWrite = 1'b1;
    w.epcWrite = 1'b1;
    s = '0;
    s.aluSrcA = `CU_SRCA_PC;
    s.aluSrcB = `CU_SRCB_FOUR;
    s.pcSource = `CU_PCSRC_EXC;
    checkCycle(testName, w, s, `CU_ALU_SUB, cause, 1'b0);
  endtask

  // Steps through Fetch1 and Fetch2 and stops in the Decode cycle
  task automatic runFetch(input string testName);
    cuPkg::writeEnablesT w;
    cuPkg::muxSelectsT   s;
    w = '0;
    w.pcWrite = 1'b1;
    s = '0;
    s.aluSrcA = `CU_SRCA_PC;
    s.aluSrcB = `CU_SRCB_FOUR;
    s.pcSource = `CU_PCSRC_ALU;
    nextCycle();
    checkCycle({testName, " Fetch1"}, w, s, `CU_ALU_ADD, cuPkg::None, 1'b0);
    w = '0;
    w.irWrite = 1'b1;
    nextCycle();
    checkCycle({testName, " Fetch2"}, w, '0, `CU_ALU_PASS, cuPkg::None, 1'b0);
    w = '0;
    w.aWrite = 1'b1;
    w.bWrite = 1'b1;
    nextCycle();
    checkCycle({testName, " Decode"}, w, '0, `CU_ALU_PASS, cuPkg::None, 1'b0);
  endtask

  // Ack responder that returns in the hiWrite cycle
  task automatic runHandshake(input string testName, input logic isDiv, input int fileDelay);
    int delay;
    int waited;
    if (fileDelay < 0) begin
      delay = $urandom % MaxRandomDelay;
    end else begin
      delay = fileDelay;
    end
    waited = 0;
    while (waited < delay) begin
      checkBit({testName, " req held"}, 1'b1, muldivReq);
      checkBit({testName, " muldivDiv"}, isDiv, muldivDiv);
      checkWrites({testName, " request"}, '0, writes);
      nextCycle();
      waited++;
    end
    checkBit({testName, " req before ack"}, 1'b1, muldivReq);
    checkBit({testName, " muldivDiv"}, isDiv, muldivDiv);
    muldivAck = 1'b1;
    waited = 0;
    nextCycle();
    while (muldivReq && waited < WaitLimit) begin
      nextCycle();
      waited++;
    end
    if (muldivReq) begin
      $display("Timeout in %s: muldivReq stayed high after ack was raised", testName);
      stopRun();
    end
    // Ack held as long again before the four-phase release
    waited = 0;
    while (waited < delay) begin
      checkBit({testName, " req low while ack held"}, 1'b0, muldivReq);
      checkWrites({testName, " ack held"}, '0, writes);
      nextCycle();
      waited++;
    end
    muldivAck = 1'b0;
    waited = 0;
    nextCycle();
    while (!writes.hiWrite && waited < WaitLimit) begin
      checkWrites({testName, " release"}, '0, writes);
      nextCycle();
      waited++;
    end
    if (!writes.hiWrite) begin
      $display("Timeout in %s: hiWrite never pulsed after ack was dropped", testName);
      stopRun();
    end
  endtask

  task automatic runLine(input int lineNo, input cuPkg::opcodeT op, input cuPkg::functT fn,
                         input cuPkg::flagsT fl, input int ackDelay,
                         input cuPkg::writeEnablesT expW, input cuPkg::muxSelectsT expS,
                         input cuPkg::aluOpT expA, input cuPkg::excCauseT expCause);
    string testName;
    logic  isDiv;
    logic  isMulDiv;
    testName = $sformatf("line %0d (op %h fn %h)", lineNo, op, fn);
    isDiv = (op == `CU_OP_RTYPE) && (fn == `CU_FN_DIV);
    isMulDiv = isDiv || ((op == `CU_OP_RTYPE) && (fn == `CU_FN_MULT));
    checkFetchZero({testName, " Fetch0"});
    opcode = op;
    funct = fn;
    flags = fl;
    runFetch(testName);
    nextCycle();
    if (expCause == cuPkg::InvalidOpcode) begin
      checkCycle({testName, " exception"}, expW, expS, expA, expCause, 1'b0);
      nextCycle();
    end else if (isMulDiv && expCause == cuPkg::DivZero) begin
      checkCycle({testName, " no request"}, '0, '0, `CU_ALU_PASS, cuPkg::None, 1'b0);
      nextCycle();
      checkCycle({testName, " exception"}, expW, expS, expA, expCause, 1'b0);
      nextCycle();
    end else if (isMulDiv) begin
      runHandshake(testName, isDiv, ackDelay);
      checkCycle({testName, " hi/lo write"}, expW, expS, expA, cuPkg::None, 1'b0);
      nextCycle();
      checkBit({testName, " single hiWrite pulse"}, 1'b0, writes.hiWrite);
    end else begin
      checkCycle({testName, " execute"}, expW, expS, expA, cuPkg::None, 1'b0);
      nextCycle();
      if (expCause == cuPkg::Overflow) begin
        checkException({testName, " exception"}, cuPkg::Overflow);
        nextCycle();
      end
    end
  endtask

  initial begin
    int           fd;
    int           code;
    int           fields;
    int           lineNo;
    int           lineCount;
    int           ovf;
    int           divZero;
    int           ackDelay;
    int           causeNum;
    string        line;
    logic [7:0]   opIn;
    logic [7:0]   fnIn;
    logic [8:0]   wIn;
    logic [11:0]  sIn;
    logic [2:0]   aIn;
    cuPkg::flagsT fl;
    lineNo = 0;
    lineCount = 0;
    void'($urandom(98));
    clk = 1'b0;
    reset = 1'b1;
    opcode = '0;
    funct = '0;
    flags = '0;
    muldivAck = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    checkFetchZero("after reset");
    fd = $fopen("sim/cu_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file sim/cu_stimulus.txt");
      stopRun();
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code != 0) begin
        lineNo++;
        fields = $sscanf(line, "%h %h %d %d %d %b %b %b %d", opIn, fnIn, ovf, divZero,
                         ackDelay, wIn, sIn, aIn, causeNum);
        // Comment and blank lines do not parse
        if (fields == 9) begin
          lineCount++;
          fl.overflow = ovf[0];
          fl.divZero = divZero[0];
          runLine(lineNo, opIn[5:0], fnIn[5:0], fl, ackDelay, wIn, sIn, aIn,
                  cuPkg::excCauseT'(causeNum[1:0]));
        end
      end
    end
    $fclose(fd);
    if (lineCount == 0) begin
      $display("The stimulus file held no instruction lines");
      stopRun();
    end
    checkFetchZero("end of run");
    $display("No errors");
    $finish;
  end

endmodule

/* src/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
  input  logic                clk,
  input  logic                reset,
  input  cuPkg::opcodeT       opcode,
  input  cuPkg::functT        funct,
  input  cuPkg::flagsT        flags,
  input  logic                muldivAck,
  output cuPkg::writeEnablesT writes,
  output cuPkg::muxSelectsT   selects,
  output cuPkg::aluOpT        aluOp,
  output logic                muldivReq,
  output logic                muldivDiv,
  output cuPkg::excCauseT     excCause
);

  cuPkg::instrKindT kind;
  cuPkg::instrKindT latchedKind;
  cuPkg::cuStateT   state;
  cuPkg::trapT      trap;

  opcodeDecoder i_opcodeDecoder (
    .opcode (opcode),
    .funct  (funct),
    .kind   (kind)
  );

  controlSequencer i_controlSequencer (
    .clk         (clk),
    .reset       (reset),
    .kind        (kind),
    .trap        (trap),
    .muldivAck   (muldivAck),
    .state       (state),
    .latchedKind (latchedKind),
    .excCause    (excCause)
  );

  controlWordGen i_controlWordGen (
    .state       (state),
    .latchedKind (latchedKind),
    .decodeKind  (kind),
    .flags       (flags),
    .writes      (writes),
    .selects     (selects),
    .aluOp       (aluOp),
    .muldivReq   (muldivReq),
    .muldivDiv   (muldivDiv),
    .trap        (trap)
  );

endmodule

/* src/controlWordGen.sv */
`timescale 1ns/1ps
`include "cu_macros.svh"

module controlWordGen (
  input  cuPkg::cuStateT      state,
  input  cuPkg::instrKindT    latchedKind,
  input  cuPkg::instrKindT    decodeKind,
  input  cuPkg::flagsT        flags,
  output cuPkg::writeEnablesT writes,
  output cuPkg::muxSelectsT   selects,
  output cuPkg::aluOpT        aluOp,
  output logic                muldivReq,
  output logic                muldivDiv,
  output cuPkg::trapT         trap
);

  logic overflowKind;
  logic inMulDiv;

  assign overflowKind = (latchedKind == cuPkg::KindAdd) || (latchedKind == cuPkg::KindSub) ||
                        (latchedKind == cuPkg::KindAddi);
  assign inMulDiv = (state == cuPkg::MdRequest) || (state == cuPkg::MdRelease) ||
                    (state == cuPkg::MdWrite);

  always_comb begin
    writes = '0;
    selects = '0;
    aluOp = `CU_ALU_PASS;
    muldivReq = 1'b0;
    muldivDiv = inMulDiv && (latchedKind == cuPkg::KindDiv);
    trap = '{valid: 1'b0, cause: cuPkg::None};

    case (state)
      cuPkg::Fetch0: begin
        selects.iorD = `CU_IORD_PC;
      end
      cuPkg::Fetch1: begin
        // PC + 4
        writes.pcWrite = 1'b1;
        selects.aluSrcA = `CU_SRCA_PC;
        selects.aluSrcB = `CU_SRCB_FOUR;
        selects.pcSource = `CU_PCSRC_ALU;
        aluOp = `CU_ALU_ADD;
      end
      cuPkg::Fetch2: begin
        writes.irWrite = 1'b1;
      end
      cuPkg::Decode: begin
        writes.aWrite = 1'b1;
        writes.bWrite = 1'b1;
        if (decodeKind == cuPkg::KindInvalid) begin
          trap = '{valid: 1'b1, cause: cuPkg::InvalidOpcode};
        end
      end
      cuPkg::Execute: begin
        case (latchedKind)
          cuPkg::KindAdd, cuPkg::KindSub, cuPkg::KindAnd, cuPkg::KindSlt: begin
            writes.regWrite = 1'b1;
            selects.aluSrcA = `CU_SRCA_REGA;
            selects.aluSrcB = `CU_SRCB_REGB;
            selects.regDst = `CU_REGDST_RD;
            selects.memToReg = `CU_M2R_ALU;
            case (latchedKind)
              cuPkg::KindSub: aluOp = `CU_ALU_SUB;
              cuPkg::KindAnd: aluOp = `CU_ALU_AND;
              cuPkg::KindSlt: aluOp = `CU_ALU_SLT;
              default:        aluOp = `CU_ALU_ADD;
            endcase
          end
          cuPkg::KindAddi, cuPkg::KindAddiu, cuPkg::KindSlti: begin
            writes.regWrite = 1'b1;
            selects.aluSrcA = `CU_SRCA_REGA;
            selects.aluSrcB = `CU_SRCB_IMM;
            selects.regDst = `CU_REGDST_RT;
            selects.memToReg = `CU_M2R_ALU;
            aluOp = (latchedKind == cuPkg::KindSlti) ? `CU_ALU_SLT : `CU_ALU_ADD;
          end
          cuPkg::KindLui: begin
            writes.regWrite = 1'b1;
            selects.regDst = `CU_REGDST_RT;
            selects.memToReg = `CU_M2R_LUI;
          end
          cuPkg::KindSw: begin
            // Address is A + sign-extended offset
            writes.memWrite = 1'b1;
            selects.aluSrcA = `CU_SRCA_REGA;
            selects.aluSrcB = `CU_SRCB_IMM;
            selects.iorD = `CU_IORD_ALU;
            aluOp = `CU_ALU_ADD;
          end
          cuPkg::KindMfhi, cuPkg::KindMflo: begin
            writes.regWrite = 1'b1;
            selects.regDst = `CU_REGDST_RD;
            selects.memToReg = (latchedKind == cuPkg::KindMfhi) ? `CU_M2R_HI : `CU_M2R_LO;
          end
          cuPkg::KindJ: begin
            writes.pcWrite = 1'b1;
            selects.pcSource = `CU_PCSRC_JUMP;
          end
          cuPkg::KindJal: begin
            // Link register gets the already incremented PC
            writes.pcWrite = 1'b1;
            writes.regWrite = 1'b1;
            selects.regDst = `CU_REGDST_RA;
            selects.memToReg = `CU_M2R_PC;
            selects.pcSource = `CU_PCSRC_JUMP;
          end
          cuPkg::KindJr: begin
            writes.pcWrite = 1'b1;
            selects.pcSource = `CU_PCSRC_REGA;
          end
          default: begin
          end
        endcase
        if (overflowKind && flags.overflow) begin
          writes.regWrite = 1'b0;
          trap = '{valid: 1'b1, cause: cuPkg::Overflow};
        end
      end
      cuPkg::MdRequest: begin
        if (latchedKind == cuPkg::KindDiv && flags.divZero) begin
          trap = '{valid: 1'b1, cause: cuPkg::DivZero};
        end else begin
          muldivReq = 1'b1;
        end
      end
      cuPkg::MdWrite: begin
        writes.hiWrite = 1'b1;
        writes.loWrite = 1'b1;
      end
      cuPkg::Exception: begin
        // EPC takes PC - 4, PC jumps to the handler
        writes.epcWrite = 1'b1;
        writes.pcWrite = 1'b1;
        selects.aluSrcA = `CU_SRCA_PC;
        selects.aluSrcB = `CU_SRCB_FOUR;
        selects.pcSource = `CU_PCSRC_EXC;
        aluOp = `CU_ALU_SUB;
      end
      default: begin
      end
    endcase
  end

endmodule

/* src/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer (
  input  logic             clk,
  input  logic             reset,
  input  cuPkg::instrKindT kind,
  input  cuPkg::trapT      trap,
  input  logic             muldivAck,
  output cuPkg::cuStateT   state,
  output cuPkg::instrKindT latchedKind,
  output cuPkg::excCauseT  excCause
);

  cuPkg::cuStateT nextState;

  always_comb begin
    nextState = state;
    case (state)
      cuPkg::Fetch0: begin
        nextState = cuPkg::Fetch1;
      end
      cuPkg::Fetch1: begin
        nextState = cuPkg::Fetch2;
      end
      cuPkg::Fetch2: begin
        nextState = cuPkg::Decode;
      end
      cuPkg::Decode: begin
        if (trap.valid) begin
          nextState = cuPkg::Exception;
        end else if (kind == cuPkg::KindMult || kind == cuPkg::KindDiv) begin
          nextState = cuPkg::MdRequest;
        end else begin
          nextState = cuPkg::Execute;
        end
      end
      cuPkg::Execute: begin
        // Overflow on add, sub or addi
        if (trap.valid) begin
          nextState = cuPkg::Exception;
        end else begin
          nextState = cuPkg::Fetch0;
        end
      end
      cuPkg::MdRequest: begin
        if (trap.valid) begin
          nextState = cuPkg::Exception;
        end else if (muldivAck) begin
          nextState = cuPkg::MdRelease;
        end
      end
      cuPkg::MdRelease: begin
        // Wait for the unit to drop ack
        if (!muldivAck) begin
          nextState = cuPkg::MdWrite;
        end
      end
      cuPkg::MdWrite: begin
        nextState = cuPkg::Fetch0;
      end
      cuPkg::Exception: begin
        nextState = cuPkg::Fetch0;
      end
      default: begin
        nextState = cuPkg::Fetch0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cuPkg::Fetch0;
    end else begin
      state <= nextState;
    end
  end

  // Instruction held for the execute and mult/div phases
  always_ff @(posedge clk) begin
    if (reset) begin
      latchedKind <= cuPkg::KindInvalid;
    end else if (state == cuPkg::Decode) begin
      latchedKind <= kind;
    end
  end

  // Cause is only non-None during the Exception cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      excCause <= cuPkg::None;
    end else if (trap.valid) begin
      excCause <= trap.cause;
    end else begin
      excCause <= cuPkg::None;
    end
  end

endmodule

/* src/opcodeDecoder.sv */
`timescale 1ns/1ps
`include "cu_macros.svh"

module opcodeDecoder (
  input  cuPkg::opcodeT    opcode,
  input  cuPkg::functT     funct,
  output cuPkg::instrKindT kind
);

  cuPkg::instrKindT rKind;

  // R-type group, selected by funct
  always_comb begin
    case (funct)
      `CU_FN_ADD: begin
        rKind = cuPkg::KindAdd;
      end
      `CU_FN_SUB: begin
        rKind = cuPkg::KindSub;
      end
      `CU_FN_AND: begin
        rKind = cuPkg::KindAnd;
      end
      `CU_FN_SLT: begin
        rKind = cuPkg::KindSlt;
      end
      `CU_FN_JR: begin
        rKind = cuPkg::KindJr;
      end
      `CU_FN_MFHI: begin
        rKind = cuPkg::KindMfhi;
      end
      `CU_FN_MFLO: begin
        rKind = cuPkg::KindMflo;
      end
      `CU_FN_MULT: begin
        rKind = cuPkg::KindMult;
      end
      `CU_FN_DIV: begin
        rKind = cuPkg::KindDiv;
      end
      default: begin
        rKind = cuPkg::KindInvalid;
      end
    endcase
  end

  always_comb begin
    case (opcode)
      `CU_OP_RTYPE: begin
        kind = rKind;
      end
      `CU_OP_ADDI: begin
        kind = cuPkg::KindAddi;
      end
      `CU_OP_ADDIU: begin
        kind = cuPkg::KindAddiu;
      end
      `CU_OP_SLTI: begin
        kind = cuPkg::KindSlti;
      end
      `CU_OP_LUI: begin
        kind = cuPkg::KindLui;
      end
      `CU_OP_SW: begin
        kind = cuPkg::KindSw;
      end
      `CU_OP_J: begin
        kind = cuPkg::KindJ;
      end
      `CU_OP_JAL: begin
        kind = cuPkg::KindJal;
      end
      default: begin
        kind = cuPkg::KindInvalid;
      end
    endcase
  end

endmodule

/* src/cuPkg.sv */
`include "cu_macros.svh"

package cuPkg;

  typedef logic [`CU_OPCODE_W-1:0] opcodeT;
  typedef logic [`CU_FUNCT_W-1:0]  functT;
  typedef logic [`CU_ALUOP_W-1:0]  aluOpT;

  // One value per supported instruction
  typedef enum logic [4:0] {
    KindAdd,
    KindSub,
    KindAnd,
    KindSlt,
    KindJr,
    KindMfhi,
    KindMflo,
    KindMult,
    KindDiv,
    KindAddi,
    KindAddiu,
    KindSlti,
    KindLui,
    KindSw,
    KindJ,
    KindJal,
    KindInvalid
  } instrKindT;

  typedef enum logic [3:0] {
    Fetch0,
    Fetch1,
    Fetch2,
    Decode,
    Execute,
    MdRequest,
    MdRelease,
    MdWrite,
    Exception
  } cuStateT;

  typedef enum logic [1:0] {
    None,
    Overflow,
    InvalidOpcode,
    DivZero
  } excCauseT;

  typedef struct packed {
    logic pcWrite;
    logic irWrite;
    logic aWrite;
    logic bWrite;
    logic regWrite;
    logic memWrite;
    logic hiWrite;
    logic loWrite;
    logic epcWrite;
  } writeEnablesT;

  typedef struct packed {
    logic                      aluSrcA;
    logic [1:0]                aluSrcB;
    logic [`CU_REGDST_W-1:0]   regDst;
    logic [`CU_MEMTOREG_W-1:0] memToReg;
    logic [`CU_IORD_W-1:0]     iorD;
    logic [`CU_PCSRC_W-1:0]    pcSource;
  } muxSelectsT;

  // Status from ALU and divider
  typedef struct packed {
    logic overflow;
    logic divZero;
  } flagsT;

  typedef struct packed {
    logic     valid;
    excCauseT cause;
  } trapT;

endpackage

/* src/cu_macros.svh */
`ifndef CU_MACROS_SVH
`define CU_MACROS_SVH

`define CU_OPCODE_W   6
`define CU_FUNCT_W    6
`define CU_ALUOP_W    3
`define CU_REGDST_W   2
`define CU_MEMTOREG_W 3
`define CU_IORD_W     2
`define CU_PCSRC_W    2

// Opcodes
`define CU_OP_RTYPE 6'b000000
`define CU_OP_J     6'b000010
`define CU_OP_JAL   6'b000011
`define CU_OP_ADDI  6'b001000
`define CU_OP_ADDIU 6'b001001
`define CU_OP_SLTI  6'b001010
`define CU_OP_LUI   6'b001111
`define CU_OP_SW    6'b101011

// R-type functs
`define CU_FN_JR   6'b001000
`define CU_FN_MFHI 6'b010000
`define CU_FN_MFLO 6'b010010
`define CU_FN_MULT 6'b011000
`define CU_FN_DIV  6'b011010
`define CU_FN_ADD  6'b100000
`define CU_FN_SUB  6'b100010
`define CU_FN_AND  6'b100100
`define CU_FN_SLT  6'b101010

// ALU operations
`define CU_ALU_PASS 3'b000
`define CU_ALU_ADD  3'b001
`define CU_ALU_SUB  3'b010
`define CU_ALU_AND  3'b011
`define CU_ALU_SLT  3'b111

// Datapath mux codes
`define CU_SRCA_PC     1'b0
`define CU_SRCA_REGA   1'b1
`define CU_SRCB_REGB   2'b00
`define CU_SRCB_FOUR   2'b01
`define CU_SRCB_IMM    2'b10
`define CU_REGDST_RT   2'b00
`define CU_REGDST_RD   2'b01
`define CU_REGDST_RA   2'b10
`define CU_M2R_ALU     3'b000
`define CU_M2R_PC      3'b001
`define CU_M2R_HI      3'b010
`define CU_M2R_LO      3'b011
`define CU_M2R_LUI     3'b100
`define CU_IORD_PC     2'b00
`define CU_IORD_ALU    2'b01
`define CU_PCSRC_ALU   2'b00
`define CU_PCSRC_JUMP  2'b01
`define CU_PCSRC_REGA  2'b10
`define CU_PCSRC_EXC   2'b11

`endif
